/* verilog/bch_pkg.sv */
/*
  BCH(15,7) t=2 code over GF(2^4)
  field and code constants, bus structs,
  FSM state enums, GF multiply and alpha power helpers
*/
package bch_pkg;

  // ------------------------------------------------
  // field and code
  // ------------------------------------------------
  localparam int M      = 4;
  localparam int N      = 15;
  localparam int T      = 2;
  localparam int T2     = 2 * T;
  // x^4 + x + 1
  localparam int IRRPOL = 19;

  typedef logic [M-1:0] gf_t;
  typedef logic         ptr_t;
  typedef logic [3:0]   pos_t;

  // ------------------------------------------------
  // buses between stages
  // ------------------------------------------------
  typedef struct packed {
    gf_t [T2:1] syn;
    ptr_t       ptr;
  } syn_bus_t;

  typedef struct packed {
    gf_t [T:0] lam;
    ptr_t      ptr;
  } loc_bus_t;

  // decfail only valid together with last
  typedef struct packed {
    logic data;
    logic last;
    logic decfail;
  } dec_out_t;

  typedef enum logic [2:0] {
    BM_RESET,
    BM_WAIT,
    BM_STEP1,
    BM_STEP2,
    BM_STEP3,
    BM_STEP4
  } bm_state_e;

  typedef enum logic {
    CH_IDLE,
    CH_SCAN
  } chien_state_e;

  // ------------------------------------------------
  // GF(2^M) helpers
  // ------------------------------------------------
  function automatic gf_t gf_mult(input gf_t a, input gf_t b);
    logic [2*M-2:0] prod;
    prod = '0;
    // carry-less product
    for (int i = 0; i < M; i++) begin
      if (b[i]) begin
        prod = prod ^ ((2*M-1)'(a) << i);
      end
    end
    // fold high terms back with the field polynomial
    for (int i = 2*M-2; i >= M; i--) begin
      if (prod[i]) begin
        prod = prod ^ (2*M-1)'(IRRPOL << (i - M));
      end
    end
    return prod[M-1:0];
  endfunction

  function automatic gf_t gf_alpha_pow(input int k);
    gf_t acc;
    acc = gf_t'(1);
    for (int i = 0; i < (k % N); i++) begin
      acc = gf_mult(acc, gf_t'(2));
    end
    return acc;
  endfunction

endpackage

/* verilog/bch_syndrome.sv */
/*
  serial syndrome unit
  Horner accumulation of S1..S4 per received bit,
  frame buffer write side, syndrome result register
*/
`timescale 1ns/1ns

module bch_syndrome (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              in_valid,
  output logic              in_ready,
  input  logic              in_bit,
  input  logic              slot_free,
  output logic              wr_en,
  output bch_pkg::ptr_t     wr_ptr,
  output bch_pkg::pos_t     wr_pos,
  output logic              wr_bit,
  output logic              syn_valid,
  input  logic              syn_ready,
  output bch_pkg::syn_bus_t syn_bus
);

  bch_pkg::gf_t [bch_pkg::T2:1] acc;
  bch_pkg::gf_t [bch_pkg::T2:1] acc_nxt;
  bch_pkg::pos_t                pos;
  bch_pkg::ptr_t                ptr;
  logic                         first;
  logic                         accept;
  logic                         frame_end;

  // ------------------------------------------------
  // input handshake
  // ------------------------------------------------
  assign first     = (pos == bch_pkg::pos_t'(bch_pkg::N - 1));
  // stall on pending result, or no slot for a new frame
  assign in_ready  = ~syn_valid & (slot_free | ~first);
  assign accept    = in_valid & in_ready;
  assign frame_end = accept & (pos == '0);

  // every accepted bit also lands in the buffer
  assign wr_en  = accept;
  assign wr_ptr = ptr;
  assign wr_pos = pos;
  assign wr_bit = in_bit;

  // ------------------------------------------------
  // Horner step  Sj = Sj * a^j + r
  // ------------------------------------------------
  always_comb begin
    for (int j = 1; j <= bch_pkg::T2; j++) begin
      // restart from zero on position n-1
      acc_nxt[j] = bch_pkg::gf_mult(first ? bch_pkg::gf_t'(0) : acc[j],
                                    bch_pkg::gf_alpha_pow(j))
                   ^ bch_pkg::gf_t'(in_bit);
    end
  end

  always_ff @(posedge iclk) begin
    if (accept) begin
      acc <= acc_nxt;
    end
    // result latched with the slot it was written to
    if (frame_end) begin
      syn_bus.syn <= acc_nxt;
      syn_bus.ptr <= ptr;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      pos       <= bch_pkg::pos_t'(bch_pkg::N - 1);
      ptr       <= '0;
      syn_valid <= 1'b0;
    end
    else begin
      if (accept) begin
        pos <= frame_end ? bch_pkg::pos_t'(bch_pkg::N - 1) : pos - 1'b1;
      end
      if (frame_end) begin
        ptr       <= ~ptr;
        syn_valid <= 1'b1;
      end
      else if (syn_valid & syn_ready) begin
        syn_valid <= 1'b0;
      end
    end
  end

  // buffer must never be written into a slot still owned downstream
  a_wr_slot_free : assert property (@(posedge iclk) disable iff (ireset)
    wr_en |-> slot_free);

endmodule

/* verilog/bch_frame_buffer.sv */
/*
  two slot frame store
  bit writes from the syndrome unit, bit reads for the Chien search,
  busy flag per slot, own next write pointer
*/
`timescale 1ns/1ns

module bch_frame_buffer (
  input  logic          iclk,
  input  logic          ireset,
  input  logic          wr_en,
  input  bch_pkg::ptr_t wr_ptr,
  input  bch_pkg::pos_t wr_pos,
  input  logic          wr_bit,
  output logic          slot_free,
  input  bch_pkg::ptr_t rd_ptr,
  input  bch_pkg::pos_t rd_pos,
  output logic          rd_bit,
  input  logic          rel_en,
  input  bch_pkg::ptr_t rel_ptr
);

  logic [bch_pkg::N-1:0] frame [2];
  logic [1:0]            busy;
  bch_pkg::ptr_t         nxt_ptr;
  logic                  wr_done;

  // position 0 closes a frame
  assign wr_done = wr_en & (wr_pos == '0);

  // ------------------------------------------------
  // storage
  // ------------------------------------------------
  always_ff @(posedge iclk) begin
    if (wr_en) begin
      frame[wr_ptr][wr_pos] <= wr_bit;
    end
  end

  assign rd_bit = frame[rd_ptr][rd_pos];

  // ------------------------------------------------
  // slot ownership
  // ------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy    <= '0;
      nxt_ptr <= '0;
    end
    else begin
      if (wr_done) begin
        busy[wr_ptr] <= 1'b1;
        nxt_ptr      <= ~nxt_ptr;
      end
      // Chien done with this frame
      if (rel_en) begin
        busy[rel_ptr] <= 1'b0;
      end
    end
  end

  assign slot_free = ~busy[nxt_ptr];

  a_rel_busy : assert property (@(posedge iclk) disable iff (ireset)
    rel_en |-> busy[rel_ptr]);

endmodule

/* verilog/bch_berlekamp_ibm.sv */
/*
  inversionless Berlekamp-Massey, binary skip form
  T iterations of four steps on T+1 shared multipliers,
  locator result in a holding register with valid/ready
*/
`timescale 1ns/1ns

module bch_berlekamp_ibm (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              syn_valid,
  output logic              syn_ready,
  input  bch_pkg::syn_bus_t syn_bus,
  output logic              loc_valid,
  input  logic              loc_ready,
  output bch_pkg::loc_bus_t loc_bus
);

  localparam int T    = bch_pkg::T;
  localparam int T2   = bch_pkg::T2;
  localparam int M    = bch_pkg::M;
  localparam int CNTW = $clog2(T + 1);

  bch_pkg::bm_state_e state;
  bch_pkg::gf_t       syn_win [-T:T2];
  bch_pkg::gf_t       l_poly  [-1:T];
  bch_pkg::gf_t       b_poly  [-2:T];
  bch_pkg::gf_t       mult    [0:T];
  bch_pkg::gf_t       disc;
  bch_pkg::gf_t       delta;
  bch_pkg::gf_t       sigma;
  logic [M-1:0]       kv;
  logic [CNTW-1:0]    cnt;
  logic               last_iter;
  logic               start;
  bch_pkg::ptr_t      ptr_lat;

  assign syn_ready = (state == bch_pkg::BM_WAIT) & ~loc_valid;
  assign start     = syn_valid & syn_ready;
  assign last_iter = (cnt == CNTW'(1));

  // ------------------------------------------------
  // FSM and iteration count
  // ------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= bch_pkg::BM_RESET;
      cnt       <= '0;
      loc_valid <= 1'b0;
    end
    else begin
      case (state)
        bch_pkg::BM_RESET : state <= bch_pkg::BM_WAIT;
        bch_pkg::BM_WAIT  : state <= start ? bch_pkg::BM_STEP1 : bch_pkg::BM_WAIT;
        bch_pkg::BM_STEP1 : state <= bch_pkg::BM_STEP2;
        bch_pkg::BM_STEP2 : state <= bch_pkg::BM_STEP3;
        bch_pkg::BM_STEP3 : state <= bch_pkg::BM_STEP4;
        bch_pkg::BM_STEP4 : state <= last_iter ? bch_pkg::BM_WAIT : bch_pkg::BM_STEP1;
        default           : state <= bch_pkg::BM_RESET;
      endcase
      if (state == bch_pkg::BM_WAIT) begin
        cnt <= CNTW'(T);
      end
      else if (state == bch_pkg::BM_STEP4) begin
        cnt <= cnt - 1'b1;
      end
      // result held until Chien takes it
      if ((state == bch_pkg::BM_STEP4) & last_iter) begin
        loc_valid <= 1'b1;
      end
      else if (loc_valid & loc_ready) begin
        loc_valid <= 1'b0;
      end
    end
  end

  // ------------------------------------------------
  // shared multiplier bank
  // ------------------------------------------------
  // step1  l * S window, later steps  poly * delta
  always_ff @(posedge iclk) begin
    for (int i = 0; i <= T; i++) begin
      mult[i] <= bch_pkg::gf_mult(
        (state == bch_pkg::BM_STEP3) ? b_poly[i-1] : l_poly[i],
        (state == bch_pkg::BM_STEP1) ? syn_win[1-i] : delta);
    end
  end

  // discrepancy is the sum of the step1 products
  always_comb begin
    disc = '0;
    for (int i = 0; i <= T; i++) begin
      disc = disc ^ mult[i];
    end
  end

  // ------------------------------------------------
  // polynomial updates
  // ------------------------------------------------
  always_ff @(posedge iclk) begin
    case (state)
      bch_pkg::BM_WAIT : begin
        if (start) begin
          for (int i = -T; i <= T2; i++) begin
            syn_win[i] <= (i < 1) ? '0 : syn_bus.syn[i];
          end
          for (int i = -1; i <= T; i++) begin
            l_poly[i] <= (i == 0) ? bch_pkg::gf_t'(1) : '0;
          end
          for (int i = -2; i <= T; i++) begin
            b_poly[i] <= (i == 0) ? bch_pkg::gf_t'(1) : '0;
          end
          sigma   <= bch_pkg::gf_t'(1);
          kv      <= '0;
          ptr_lat <= syn_bus.ptr;
        end
      end
      bch_pkg::BM_STEP1 : begin
        // skip even steps, window moves by two
        for (int i = -T; i <= T2 - 2; i++) begin
          syn_win[i] <= syn_win[i+2];
        end
        // delta borrowed to carry sigma into step2
        delta <= sigma;
      end
      bch_pkg::BM_STEP2 : begin
        delta <= disc;
      end
      bch_pkg::BM_STEP3 : begin
        for (int i = 0; i <= T; i++) begin
          l_poly[i] <= mult[i];
        end
        if ((delta != '0) & ~kv[M-1]) begin
          // b = z * lambda
          for (int i = 0; i <= T; i++) begin
            b_poly[i] <= l_poly[i-1];
          end
          sigma <= delta;
          kv    <= -kv;
        end
        else begin
          // b = z^2 * b
          for (int i = 0; i <= T; i++) begin
            b_poly[i] <= b_poly[i-2];
          end
          kv <= kv + M'(2);
        end
      end
      bch_pkg::BM_STEP4 : begin
        for (int i = 0; i <= T; i++) begin
          l_poly[i] <= l_poly[i] ^ mult[i];
        end
        if (last_iter) begin
          for (int i = 0; i <= T; i++) begin
            // kv below zero means more than T errors
            // a zero lambda then fails the root count in Chien
            loc_bus.lam[i] <= kv[M-1] ? '0 : (l_poly[i] ^ mult[i]);
          end
          loc_bus.ptr <= ptr_lat;
        end
      end
      default : begin
      end
    endcase
  end

  // fixed 4T+1 latency from syndrome transfer to locator
  a_latency : assert property (@(posedge iclk) disable iff (ireset)
    start |-> ##(4*T+1) $rose(loc_valid));

endmodule

/* verilog/bch_chien_correct.sv */
/*
  Chien search with inline correction
  locator evaluation from position 14 down to 0,
  bit flip on root, root count against degree for decfail
*/
`timescale 1ns/1ns

module bch_chien_correct (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              loc_valid,
  output logic              loc_ready,
  input  bch_pkg::loc_bus_t loc_bus,
  output bch_pkg::ptr_t     rd_ptr,
  output bch_pkg::pos_t     rd_pos,
  input  logic              rd_bit,
  output logic              rel_en,
  output bch_pkg::ptr_t     rel_ptr,
  output logic              out_valid,
  input  logic              out_ready,
  output bch_pkg::dec_out_t out_data
);

  localparam int T  = bch_pkg::T;
  localparam int DW = $clog2(T + 1);

  bch_pkg::chien_state_e    state;
  bch_pkg::gf_t [T:0]       term;
  bch_pkg::gf_t             eval;
  logic [DW-1:0]            deg_in;
  logic [DW-1:0]            deg;
  bch_pkg::pos_t            roots;
  bch_pkg::pos_t            roots_now;
  bch_pkg::pos_t            pos;
  bch_pkg::ptr_t            ptr;
  logic                     accept;
  logic                     beat;
  logic                     err;
  logic                     last;

  assign loc_ready = (state == bch_pkg::CH_IDLE);
  assign out_valid = (state == bch_pkg::CH_SCAN);
  assign accept    = loc_valid & loc_ready;
  assign beat      = out_valid & out_ready;
  assign last      = (pos == '0);

  // degree = highest nonzero coefficient
  always_comb begin
    deg_in = '0;
    for (int k = 1; k <= T; k++) begin
      if (loc_bus.lam[k] != '0) begin
        deg_in = DW'(k);
      end
    end
  end

  // ------------------------------------------------
  // evaluation and correction
  // ------------------------------------------------
  always_comb begin
    eval = '0;
    for (int k = 0; k <= T; k++) begin
      eval = eval ^ term[k];
    end
  end

  // lambda(a^-pos) == 0 marks an error position
  assign err       = (eval == '0);
  assign roots_now = roots + bch_pkg::pos_t'(err);

  assign rd_ptr           = ptr;
  assign rd_pos           = pos;
  assign out_data.data    = rd_bit ^ err;
  assign out_data.last    = last;
  assign out_data.decfail = last & (roots_now != bch_pkg::pos_t'(deg));

  // slot goes back to the buffer with the last beat
  assign rel_en  = beat & last;
  assign rel_ptr = ptr;

  always_ff @(posedge iclk) begin
    if (accept) begin
      // lambda_k * a^k evaluates position 14
      for (int k = 0; k <= T; k++) begin
        term[k] <= bch_pkg::gf_mult(loc_bus.lam[k], bch_pkg::gf_alpha_pow(k));
      end
      deg   <= deg_in;
      ptr   <= loc_bus.ptr;
      pos   <= bch_pkg::pos_t'(bch_pkg::N - 1);
      roots <= '0;
    end
    else if (beat) begin
      // one position down
      for (int k = 0; k <= T; k++) begin
        term[k] <= bch_pkg::gf_mult(term[k], bch_pkg::gf_alpha_pow(k));
      end
      pos   <= pos - 1'b1;
      roots <= roots_now;
    end
  end

  // ------------------------------------------------
  // FSM
  // ------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= bch_pkg::CH_IDLE;
    end
    else begin
      case (state)
        bch_pkg::CH_IDLE : state <= accept ? bch_pkg::CH_SCAN : bch_pkg::CH_IDLE;
        bch_pkg::CH_SCAN : state <= (beat & last) ? bch_pkg::CH_IDLE : bch_pkg::CH_SCAN;
        default          : state <= bch_pkg::CH_IDLE;
      endcase
    end
  end

endmodule

/* verilog/bch_decoder.sv */
/*
  BCH(15,7) t=2 serial decoder top
  syndrome unit, frame buffer, Berlekamp-Massey, Chien search
*/
`timescale 1ns/1ns

module bch_decoder (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              in_valid,
  output logic              in_ready,
  input  logic              in_bit,
  output logic              out_valid,
  input  logic              out_ready,
  output bch_pkg::dec_out_t out_data
);

  // ------------------------------------------------
  // internal links
  // ------------------------------------------------
  logic              slot_free;
  logic              wr_en;
  bch_pkg::ptr_t     wr_ptr;
  bch_pkg::pos_t     wr_pos;
  logic              wr_bit;
  bch_pkg::ptr_t     rd_ptr;
  bch_pkg::pos_t     rd_pos;
  logic              rd_bit;
  logic              rel_en;
  bch_pkg::ptr_t     rel_ptr;
  logic              syn_valid;
  logic              syn_ready;
  bch_pkg::syn_bus_t syn_bus;
  logic              loc_valid;
  logic              loc_ready;
  bch_pkg::loc_bus_t loc_bus;

  bch_syndrome syndrome_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_bit    (in_bit),
    .slot_free (slot_free),
    .wr_en     (wr_en),
    .wr_ptr    (wr_ptr),
    .wr_pos    (wr_pos),
    .wr_bit    (wr_bit),
    .syn_valid (syn_valid),
    .syn_ready (syn_ready),
    .syn_bus   (syn_bus)
  );

  // received bits wait here until corrected
  bch_frame_buffer frame_buffer_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .wr_en     (wr_en),
    .wr_ptr    (wr_ptr),
    .wr_pos    (wr_pos),
    .wr_bit    (wr_bit),
    .slot_free (slot_free),
    .rd_ptr    (rd_ptr),
    .rd_pos    (rd_pos),
    .rd_bit    (rd_bit),
    .rel_en    (rel_en),
    .rel_ptr   (rel_ptr)
  );

  bch_berlekamp_ibm berlekamp_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .syn_valid (syn_valid),
    .syn_ready (syn_ready),
    .syn_bus   (syn_bus),
    .loc_valid (loc_valid),
    .loc_ready (loc_ready),
    .loc_bus   (loc_bus)
  );

  bch_chien_correct chien_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .loc_valid (loc_valid),
    .loc_ready (loc_ready),
    .loc_bus   (loc_bus),
    .rd_ptr    (rd_ptr),
    .rd_pos    (rd_pos),
    .rd_bit    (rd_bit),
    .rel_en    (rel_en),
    .rel_ptr   (rel_ptr),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

/* test/tb_clock_gen.sv */
/*
  testbench clock and reset source
  8 ns clock, 16 cycle power-on reset, extra reset on request
*/
`timescale 1ns/1ns

module tb_clock_gen (
  input  logic reset_req,
  output logic iclk,
  output logic ireset
);

  logic por;

  // 8 ns period
  initial begin
    iclk = 1'b0;
    forever #4 iclk = ~iclk;
  end

  // power-on reset over the first 16 rising edges
  initial begin
    por = 1'b1;
    repeat (16) @(posedge iclk);
    por <= 1'b0;
  end

  // testbench can pull reset again mid-run
  assign ireset = por | reset_req;

endmodule

/* test/bch_decoder_tb.sv */
/*
  testbench for the serial BCH(15,7) decoder
  xorshift stimulus, encoder, brute force reference decoder,
  frame driver, output collector with scoreboard
*/
`timescale 1ns/1ns

module bch_decoder_tb;

  // g(x) = x^8 + x^7 + x^6 + x^4 + 1
  localparam logic [14:0] GEN_POLY   = 15'h1D1;
  localparam int          WAIT_LIMIT = 1000;

  logic              iclk;
  logic              ireset;
  logic              reset_req;
  logic              in_valid;
  logic              in_ready;
  logic              in_bit;
  logic              out_valid;
  logic              out_ready;
  bch_pkg::dec_out_t out_data;

  logic [31:0]       rng;
  logic [31:0]       stall_rng;
  logic [14:0]       rx_q [$];
  int                frames_checked;
  int                value_errors;
  int                other_errors;
  logic              hung;

  tb_clock_gen clock_gen_i (
    .reset_req (reset_req),
    .iclk      (iclk),
    .ireset    (ireset)
  );

  bch_decoder dut_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_bit    (in_bit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  // ------------------------------------------------
  // random numbers, encoder, reference decoder
  // ------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // stimulus stream only, stalls have their own state
  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // c(x) = m(x) * g(x), bit i holds the x^i coefficient
  function automatic logic [14:0] encode(input logic [6:0] msg);
    logic [14:0] cw;
    cw = '0;
    for (int i = 0; i < 7; i++) begin
      if (msg[i]) begin
        cw = cw ^ (GEN_POLY << i);
      end
    end
    return cw;
  endfunction

  // exhaustive search of all 128 codewords within distance 2
  function automatic void ref_decode(input logic [14:0] rx, output logic [14:0] cw,
                                     output logic fail);
    logic [14:0] cand;
    int          hits;
    hits = 0;
    cw   = '0;
    for (int m = 0; m < 128; m++) begin
      cand = encode(7'(m));
      if ($countones(cand ^ rx) <= 2) begin
        hits++;
        cw = cand;
      end
    end
    fail = (hits != 1);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %s expected %0h actual %0h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic note_hang(input string what);
    if (!hung) begin
      $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
      other_errors++;
    end
    hung = 1'b1;
  endtask

  // ------------------------------------------------
  // input side
  // ------------------------------------------------
  // position 14 first, one handshake per bit
  task automatic send_frame(input logic [14:0] rx, input int nbits, input bit gaps);
    int idle;
    int waited;
    for (int k = 0; k < nbits; k++) begin
      if (hung) break;
      if (gaps) begin
        idle = int'(next_rand() % 4);
        for (int i = 0; i < idle; i++) begin
          in_valid <= 1'b0;
          @(posedge iclk);
        end
      end
      in_valid <= 1'b1;
      in_bit   <= rx[14-k];
      waited   = 0;
      // in_ready only depends on DUT registers, stable at the falling edge
      @(negedge iclk);
      while (!in_ready && !hung) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          note_hang("input handshake");
        end
        @(negedge iclk);
      end
      // transfer on this edge
      @(posedge iclk);
    end
  endtask

  task automatic drive_frames(input int count, input int min_err, input int max_err,
                              input bit sweep, input bit gaps);
    logic [14:0] mask;
    logic [14:0] rx;
    logic [31:0] r;
    int          nerr;
    for (int f = 0; f < count; f++) begin
      if (hung) break;
      mask = '0;
      if (sweep) begin
        // walk one error over every position
        mask[f % 15] = 1'b1;
      end
      else begin
        nerr = min_err + int'(next_rand() % 32'(max_err - min_err + 1));
        // distinct positions
        while ($countones(mask) < nerr) begin
          mask[int'(next_rand() % 15)] = 1'b1;
        end
      end
      r  = next_rand();
      rx = encode(r[6:0]) ^ mask;
      rx_q.push_back(rx);
      send_frame(rx, 15, gaps);
    end
    in_valid <= 1'b0;
  endtask

  // ------------------------------------------------
  // output side and scoreboard
  // ------------------------------------------------
  task automatic collect_frames(input string name, input int count, input bit stall);
    logic [14:0] got;
    logic [14:0] rx;
    logic [14:0] exp_cw;
    logic        got_fail;
    logic        exp_fail;
    int          waited;
    for (int f = 0; f < count; f++) begin
      if (hung) break;
      got      = '0;
      got_fail = 1'b0;
      for (int k = 0; k < 15; k++) begin
        waited = 0;
        // offer ready each cycle until one beat is taken
        forever begin
          stall_rng = xorshift32(stall_rng);
          out_ready <= stall ? stall_rng[0] : 1'b1;
          @(negedge iclk);
          if ((out_valid && out_ready) || hung) break;
          waited++;
          if (waited > WAIT_LIMIT) begin
            note_hang("output beat");
          end
          @(posedge iclk);
        end
        if (hung) break;
        // beat k carries position 14-k
        got[14-k] = out_data.data;
        check_value({name, " last"}, 32'(k == 14), 32'(out_data.last));
        if (k == 14) begin
          got_fail = out_data.decfail;
        end
        @(posedge iclk);
      end
      if (hung) break;
      if (rx_q.size() == 0) begin
        $display("an output frame arrived with no input frame pending");
        other_errors++;
        break;
      end
      rx = rx_q.pop_front();
      ref_decode(rx, exp_cw, exp_fail);
      check_value({name, " decfail"}, 32'(exp_fail), 32'(got_fail));
      // data of a failed frame is undefined
      if (!exp_fail) begin
        check_value({name, " data"}, 32'(exp_cw), 32'(got));
      end
      frames_checked++;
    end
  endtask

  task automatic run_phase(input string name, input int count, input int min_err,
                           input int max_err, input bit sweep, input bit gaps,
                           input bit stall);
    if (!hung) begin
      @(posedge iclk);
      fork
        drive_frames(count, min_err, max_err, sweep, gaps);
        collect_frames(name, count, stall);
      join
    end
  endtask

  // one full frame held at the output, one half frame inside, then reset
  task automatic reset_mid_stream();
    logic [31:0] r;
    if (!hung) begin
      @(posedge iclk);
      out_ready <= 1'b0;
      r = next_rand();
      send_frame(encode(r[6:0]), 15, 1'b0);
      r = next_rand();
      send_frame(encode(r[6:0]), 7, 1'b0);
      in_valid <= 1'b0;
      repeat (20) @(posedge iclk);
      reset_req <= 1'b1;
      for (int i = 0; i < 16; i++) begin
        @(negedge iclk);
        check_value("reset out_valid", 32'(0), 32'(out_valid));
        @(posedge iclk);
      end
      reset_req <= 1'b0;
      @(negedge iclk);
      check_value("reset out_valid", 32'(0), 32'(out_valid));
      check_value("reset in_ready", 32'(1), 32'(in_ready));
      @(posedge iclk);
    end
  endtask

  // ------------------------------------------------
  // test sequence
  // ------------------------------------------------
  initial begin
    int waited;
    rng            = 32'h2fba4268;
    stall_rng      = xorshift32(32'h2fba4268);
    reset_req      = 1'b0;
    in_valid       = 1'b0;
    in_bit         = 1'b0;
    out_ready      = 1'b0;
    frames_checked = 0;
    value_errors   = 0;
    other_errors   = 0;
    hung           = 1'b0;
    waited         = 0;

    @(negedge iclk);
    while (ireset && !hung) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        note_hang("release of reset");
      end
      @(negedge iclk);
    end
    check_value("after reset in_ready", 32'(1), 32'(in_ready));
    check_value("after reset out_valid", 32'(0), 32'(out_valid));

    run_phase("clean", 10, 0, 0, 1'b0, 1'b1, 1'b0);
    run_phase("single", 15, 1, 1, 1'b1, 1'b1, 1'b0);
    run_phase("double", 30, 2, 2, 1'b0, 1'b1, 1'b0);
    run_phase("triple_quad", 30, 3, 4, 1'b0, 1'b1, 1'b0);
    run_phase("stall", 30, 0, 2, 1'b0, 1'b1, 1'b1);
    // in_valid stays high across bits and frames
    run_phase("burst", 12, 0, 2, 1'b0, 1'b0, 1'b0);
    reset_mid_stream();
    run_phase("after_reset", 8, 0, 2, 1'b0, 1'b1, 1'b0);

    repeat (4) @(posedge iclk);
    if (rx_q.size() != 0) begin
      $display("%0d sent frames never came out", rx_q.size());
      other_errors++;
    end
    $display("frames checked %0d, value errors %0d, other errors %0d",
             frames_checked, value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("Simulation PASSED");
    end
    else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
verilog/bch_pkg.sv
verilog/bch_syndrome.sv
verilog/bch_frame_buffer.sv
verilog/bch_berlekamp_ibm.sv
verilog/bch_chien_correct.sv
verilog/bch_decoder.sv
test/tb_clock_gen.sv
test/bch_decoder_tb.sv

/* Makefile */
TOP = bch_decoder_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f all.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
